/* source/mv_pkg.sv */
package mv_pkg;

    // vote word geometry
    localparam int word_bits = 32;
    localparam int rem_bits = 5;

    // signed vote accumulator, a job holds at most 2^19-1 bits
    localparam int count_bits = 20;

    // word counter wide enough for ceil((2^20-1)/32)
    localparam int words_bits = count_bits - rem_bits + 1;

    // adder tree split of one word
    localparam int part_count = 4;
    localparam int part_len = word_bits / part_count;
    // sum of eight votes lies in -8..8
    localparam int part_bits = 5;

    // galois taps for the tie-break generator
    localparam logic [word_bits-1:0] lfsr_taps = 32'h8020_0003;

    typedef logic [word_bits-1:0] word_t;

    typedef logic signed [count_bits-1:0] count_t;

    // one data word on its way to the counter
    typedef struct packed {
        word_t                data;
        logic                 last;
        // 0 means all 32 bits count
        logic [rem_bits-1:0]  remainder;
    } vote_word_t;

    // job setup seen by the sequencer and lfsr
    typedef struct packed {
        logic [count_bits-1:0] bit_count;
        logic                  start;
    } job_cfg_t;

endpackage

/* source/axil_pkg.sv */
package axil_pkg;

    localparam int addr_bits = 8;
    localparam int data_bits = 32;

    typedef logic [addr_bits-1:0] addr_t;
    typedef logic [data_bits-1:0] data_t;
    typedef logic [1:0] resp_t;

    // register map
    localparam addr_t reg_ctrl = 8'h00;
    localparam addr_t reg_count = 8'h04;
    localparam addr_t reg_seed = 8'h08;
    localparam addr_t reg_data = 8'h0C;
    localparam addr_t reg_status = 8'h10;

    // bresp / rresp codes
    localparam resp_t resp_okay = 2'b00;
    localparam resp_t resp_slverr = 2'b10;

    // master to slave
    typedef struct packed {
        addr_t  awaddr;
        logic   awvalid;
        data_t  wdata;
        logic   wvalid;
        logic   bready;
        addr_t  araddr;
        logic   arvalid;
        logic   rready;
    } axil_req_t;

    // slave to master
    typedef struct packed {
        logic   awready;
        logic   wready;
        resp_t  bresp;
        logic   bvalid;
        logic   arready;
        data_t  rdata;
        resp_t  rresp;
        logic   rvalid;
    } axil_rsp_t;

endpackage

/* source/axil_regs.sv */
`default_nettype none

module axil_regs (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp,
    output mv_pkg::job_cfg_t    job,
    output mv_pkg::word_t       seed,
    output logic                seed_load,
    output mv_pkg::word_t       data,
    output logic                data_valid,
    input  logic                last_done,
    input  logic                sign_bit
);

    import axil_pkg::*;
    import mv_pkg::*;

    logic                  wr_fire;
    logic                  rd_fire;
    logic                  wr_mapped;
    logic                  rd_mapped;
    data_t                 rd_word;
    logic                  bvalid;
    resp_t                 bresp;
    logic                  rvalid;
    resp_t                 rresp;
    data_t                 rdata;
    logic [count_bits-1:0] count_reg;
    word_t                 seed_reg;
    logic                  start;
    logic                  last_d;
    logic                  done;
    logic                  busy;

    // write takes address and data together, one response outstanding
    assign wr_fire = axil_req.awvalid && axil_req.wvalid && !bvalid;
    assign rd_fire = axil_req.arvalid && !rvalid;

    assign start = wr_fire && (axil_req.awaddr == reg_ctrl) && axil_req.wdata[0];

    always_comb begin
        case (axil_req.awaddr)
            reg_ctrl, reg_count, reg_seed, reg_data, reg_status: wr_mapped = 1'b1;
            default: wr_mapped = 1'b0;
        endcase
    end

    always_comb begin
        rd_mapped = 1'b1;
        case (axil_req.araddr)
            reg_count:  rd_word = data_t'(count_reg);
            reg_seed:   rd_word = seed_reg;
            reg_status: rd_word = data_t'({busy, sign_bit, done});
            reg_ctrl, reg_data: rd_word = '0;
            default: begin
                rd_word = '0;
                rd_mapped = 1'b0;
            end
        endcase
    end

    // b channel
    always_ff @(posedge clk) begin
        if (rst) begin
            bvalid <= 1'b0;
        end else if (wr_fire) begin
            bvalid <= 1'b1;
        end else if (axil_req.bready) begin
            bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            bresp <= wr_mapped ? resp_okay : resp_slverr;
        end
    end

    // r channel, answered the cycle after arvalid
    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else if (rd_fire) begin
            rvalid <= 1'b1;
        end else if (axil_req.rready) begin
            rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_fire) begin
            rdata <= rd_word;
            rresp <= rd_mapped ? resp_okay : resp_slverr;
        end
    end

    // configuration registers
    always_ff @(posedge clk) begin
        if (rst) begin
            count_reg <= '0;
            seed_reg <= '0;
            seed_load <= 1'b0;
        end else begin
            seed_load <= wr_fire && (axil_req.awaddr == reg_seed);
            if (wr_fire && (axil_req.awaddr == reg_count)) begin
                count_reg <= axil_req.wdata[count_bits-1:0];
            end
            if (wr_fire && (axil_req.awaddr == reg_seed)) begin
                seed_reg <= axil_req.wdata;
            end
        end
    end

    // job status, done lines up with the counter result
    always_ff @(posedge clk) begin
        if (rst) begin
            last_d <= 1'b0;
            done <= 1'b0;
            busy <= 1'b0;
        end else begin
            last_d <= last_done;
            if (start) begin
                done <= 1'b0;
                busy <= 1'b1;
            end else if (last_d) begin
                done <= 1'b1;
                busy <= 1'b0;
            end
        end
    end

    assign job.bit_count = count_reg;
    assign job.start = start;
    assign seed = seed_reg;
    assign data = axil_req.wdata;
    assign data_valid = wr_fire && (axil_req.awaddr == reg_data);

    always_comb begin
        axil_rsp.awready = wr_fire;
        axil_rsp.wready = wr_fire;
        axil_rsp.bresp = bresp;
        axil_rsp.bvalid = bvalid;
        axil_rsp.arready = !rvalid;
        axil_rsp.rdata = rdata;
        axil_rsp.rresp = rresp;
        axil_rsp.rvalid = rvalid;
    end

endmodule

`default_nettype wire

/* source/word_sequencer.sv */
`default_nettype none

module word_sequencer (
    input  logic               clk,
    input  logic               rst,
    input  mv_pkg::job_cfg_t   job,
    input  mv_pkg::word_t      data,
    input  logic               data_valid,
    output mv_pkg::vote_word_t word,
    output logic               update,
    output logic               clear,
    output logic               parity_even,
    output logic               last_done
);

    import mv_pkg::*;

    logic [count_bits:0]   padded;
    logic [words_bits-1:0] word_total;
    logic [words_bits-1:0] words_left;
    logic [rem_bits-1:0]   job_rem;
    logic                  accept;
    logic                  is_last;

    // ceil(bit_count / 32)
    assign padded = {1'b0, job.bit_count} + (count_bits + 1)'(word_bits - 1);
    assign word_total = padded[count_bits:rem_bits];

    // nothing left once the job is complete
    assign accept = data_valid && (words_left != '0);
    assign is_last = (words_left == words_bits'(1));

    always_ff @(posedge clk) begin
        if (rst) begin
            words_left <= '0;
            update <= 1'b0;
            clear <= 1'b0;
            last_done <= 1'b0;
            parity_even <= 1'b0;
        end else begin
            clear <= job.start;
            update <= 1'b0;
            last_done <= 1'b0;
            if (job.start) begin
                words_left <= word_total;
                parity_even <= !job.bit_count[0];
            end else if (accept) begin
                words_left <= words_left - words_bits'(1);
                update <= 1'b1;
                last_done <= is_last;
            end
        end
    end

    // remainder of the job, used on its last word only
    always_ff @(posedge clk) begin
        if (job.start) begin
            job_rem <= job.bit_count[rem_bits-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            word.data <= data;
            word.last <= is_last;
            word.remainder <= is_last ? job_rem : '0;
        end
    end

endmodule

`default_nettype wire

/* source/tie_lfsr.sv */
`default_nettype none

module tie_lfsr (
    input  logic          clk,
    input  logic          rst,
    input  mv_pkg::word_t seed,
    input  logic          seed_load,
    input  logic          step,
    output logic          tie_bit
);

    import mv_pkg::*;

    word_t state;
    word_t state_next;

    // galois form, shift right and fold the taps in on a set lsb
    always_comb begin
        state_next = state >> 1;
        if (state[0]) begin
            state_next = state_next ^ lfsr_taps;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= word_t'(1);
            tie_bit <= 1'b0;
        end else begin
            if (seed_load) begin
                // all zero state would lock up
                state <= (seed == '0) ? word_t'(1) : seed;
            end else if (step) begin
                state <= state_next;
            end
            // lsb taken before the step
            if (step) begin
                tie_bit <= state[0];
            end
        end
    end

endmodule

`default_nettype wire

/* source/majority_counter.sv */
`default_nettype none

module majority_counter (
    input  logic               clk,
    input  logic               rst,
    input  mv_pkg::vote_word_t word,
    input  logic               update,
    input  logic               clear,
    input  logic               parity_even,
    input  logic               tie_bit,
    output logic               sign_bit
);

    import mv_pkg::*;

    logic [word_bits-1:0]        masked;
    logic signed [1:0]           vote [word_bits];
    logic signed [part_bits-1:0] part_sum [part_count];
    logic signed [part_bits-1:0] part_q [part_count];
    logic                        sum_valid;
    count_t                      acc;
    count_t                      acc_next;
    count_t                      acc_init;

    // one vote per bit, bits past the remainder of the last word drop out
    generate
        for (genvar k = 0; k < word_bits; k++) begin : g_vote
            assign masked[k] = word.last && (word.remainder != '0)
                               && (rem_bits'(k) >= word.remainder);
            assign vote[k] = masked[k] ? 2'sd0 : (word.data[k] ? -2'sd1 : 2'sd1);
        end
    endgenerate

    // eight votes per partial sum
    always_comb begin
        for (int i = 0; i < part_count; i++) begin
            part_sum[i] = '0;
            for (int j = 0; j < part_len; j++) begin
                part_sum[i] = part_sum[i] + vote[i*part_len + j];
            end
        end
    end

    always_comb begin
        acc_next = acc;
        for (int i = 0; i < part_count; i++) begin
            acc_next = acc_next + part_q[i];
        end
    end

    // tie rule, an odd job cannot tie
    always_comb begin
        if (!parity_even) begin
            acc_init = '0;
        end else if (tie_bit) begin
            // minus one, ones win
            acc_init = '1;
        end else begin
            acc_init = count_t'(1);
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        if (update) begin
            part_q <= part_sum;
        end
    end

    // stage 2
    always_ff @(posedge clk) begin
        if (rst) begin
            sum_valid <= 1'b0;
            acc <= '0;
        end else begin
            sum_valid <= update;
            if (clear) begin
                acc <= acc_init;
            end else if (sum_valid) begin
                acc <= acc_next;
            end
        end
    end

    assign sign_bit = acc[count_bits-1];

endmodule

`default_nettype wire

/* source/majority_bundler.sv */
`default_nettype none

module majority_bundler (
    input  logic                clk,
    input  logic                rst,
    input  axil_pkg::axil_req_t axil_req,
    output axil_pkg::axil_rsp_t axil_rsp
);

    import mv_pkg::*;

    job_cfg_t   job;
    word_t      seed;
    logic       seed_load;
    word_t      data;
    logic       data_valid;
    vote_word_t word;
    logic       update;
    logic       clear;
    logic       parity_even;
    logic       last_done;
    logic       tie_bit;
    logic       sign_bit;

    axil_regs i_axil_regs (
        .clk        (clk),
        .rst        (rst),
        .axil_req   (axil_req),
        .axil_rsp   (axil_rsp),
        .job        (job),
        .seed       (seed),
        .seed_load  (seed_load),
        .data       (data),
        .data_valid (data_valid),
        .last_done  (last_done),
        .sign_bit   (sign_bit)
    );

    word_sequencer i_word_sequencer (
        .clk         (clk),
        .rst         (rst),
        .job         (job),
        .data        (data),
        .data_valid  (data_valid),
        .word        (word),
        .update      (update),
        .clear       (clear),
        .parity_even (parity_even),
        .last_done   (last_done)
    );

    // one tie bit drawn per job start
    tie_lfsr i_tie_lfsr (
        .clk       (clk),
        .rst       (rst),
        .seed      (seed),
        .seed_load (seed_load),
        .step      (job.start),
        .tie_bit   (tie_bit)
    );

    majority_counter i_majority_counter (
        .clk         (clk),
        .rst         (rst),
        .word        (word),
        .update      (update),
        .clear       (clear),
        .parity_even (parity_even),
        .tie_bit     (tie_bit),
        .sign_bit    (sign_bit)
    );

endmodule

`default_nettype wire

/* bench/majority_bundler_tb.sv */
module majority_bundler_tb;

    import axil_pkg::*;
    import mv_pkg::*;

    localparam int wait_limit = 20;
    localparam int poll_limit = 50;

    logic      clk;
    logic      rst;
    axil_req_t axil_req;
    axil_rsp_t axil_rsp;

    int        errors;
    int        ready_delay_max;
    // reference copy of the tie generator
    word_t     model_state;
    logic      model_tie;
    word_t     job_words[$];
    // status word the model predicts for the latest job
    data_t     expected_status;

    majority_bundler i_majority_bundler (
        .clk      (clk),
        .rst      (rst),
        .axil_req (axil_req),
        .axil_rsp (axil_rsp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic check_status(string name, data_t expected, data_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
        end
    endtask

    task automatic check_resp(string name, resp_t expected, resp_t actual);
        if (actual !== expected) begin
            errors++;
            $display("Error at %0t: %s expected %b, got %b", $time, name, expected, actual);
        end
    endtask

    task automatic abort_on_timeout(string what);
        $display("timeout while waiting for %s, the DUT stopped answering", what);
        $display("sim failed");
        $finish;
    endtask

    // called on a falling edge, returns on a falling edge
    task automatic bus_write(addr_t addr, data_t wdata, output resp_t resp);
        int n;
        int delay;
        logic accepted;
        axil_req.awaddr = addr;
        axil_req.wdata = wdata;
        axil_req.awvalid = 1'b1;
        axil_req.wvalid = 1'b1;
        // aw and w taken together on one edge
        n = 0;
        do begin
            @(posedge clk);
            accepted = axil_rsp.awready && axil_rsp.wready;
            n++;
        end while (!accepted && n < wait_limit);
        if (!accepted) begin
            abort_on_timeout("the write address and data handshake");
        end
        @(negedge clk);
        axil_req.awvalid = 1'b0;
        axil_req.wvalid = 1'b0;
        n = 0;
        while (!axil_rsp.bvalid && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!axil_rsp.bvalid) begin
            abort_on_timeout("the write response");
        end
        resp = axil_rsp.bresp;
        delay = $urandom_range(ready_delay_max, 0);
        repeat (delay) @(negedge clk);
        axil_req.bready = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (axil_rsp.bvalid && n < wait_limit);
        if (axil_rsp.bvalid) begin
            abort_on_timeout("bvalid to drop");
        end
        axil_req.bready = 1'b0;
    endtask

    task automatic bus_read(addr_t addr, output data_t rdata, output resp_t resp);
        int n;
        int delay;
        logic accepted;
        axil_req.araddr = addr;
        axil_req.arvalid = 1'b1;
        n = 0;
        do begin
            @(posedge clk);
            accepted = axil_rsp.arready;
            n++;
        end while (!accepted && n < wait_limit);
        if (!accepted) begin
            abort_on_timeout("the read address handshake");
        end
        @(negedge clk);
        axil_req.arvalid = 1'b0;
        n = 0;
        while (!axil_rsp.rvalid && n < wait_limit) begin
            @(negedge clk);
            n++;
        end
        if (!axil_rsp.rvalid) begin
            abort_on_timeout("the read data");
        end
        rdata = axil_rsp.rdata;
        resp = axil_rsp.rresp;
        delay = $urandom_range(ready_delay_max, 0);
        repeat (delay) @(negedge clk);
        axil_req.rready = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (axil_rsp.rvalid && n < wait_limit);
        if (axil_rsp.rvalid) begin
            abort_on_timeout("rvalid to drop");
        end
        axil_req.rready = 1'b0;
    endtask

    task automatic wait_done(output data_t status);
        resp_t resp;
        int n;
        n = 0;
        do begin
            bus_read(reg_status, status, resp);
            check_resp("rresp of status poll", resp_okay, resp);
            n++;
        end while (!status[0] && n < poll_limit);
        if (!status[0]) begin
            abort_on_timeout("done in the status register");
        end
    endtask

    function automatic word_t lfsr_step(word_t s);
        word_t nx;
        nx = s >> 1;
        if (s[0]) begin
            nx = nx ^ 32'h8020_0003;
        end
        return nx;
    endfunction

    // one is -1, zero is +1, tie bit seeds an even job
    function automatic logic expected_majority(int n, logic tie);
        int sum;
        sum = 0;
        for (int i = 0; i < n; i++) begin
            sum += job_words[i / 32][i % 32] ? -1 : 1;
        end
        if (n % 2 == 0) begin
            sum += tie ? -1 : 1;
        end
        return sum < 0;
    endfunction

    // adverse fill sets the unused bits against the real majority
    function automatic void make_random_job(int n, bit adverse);
        int words;
        int rem;
        int sum;
        word_t last;
        job_words.delete();
        words = (n + 31) / 32;
        for (int i = 0; i < words; i++) begin
            job_words.push_back($urandom());
        end
        rem = n % 32;
        if (adverse && rem != 0) begin
            sum = 0;
            for (int i = 0; i < n; i++) begin
                sum += job_words[i / 32][i % 32] ? -1 : 1;
            end
            last = job_words[words - 1];
            for (int b = rem; b < 32; b++) begin
                last[b] = (sum >= 0);
            end
            job_words[words - 1] = last;
        end
    endfunction

    // complementary bit pairs inside the job, so the vote sum is zero
    function automatic void make_tie_job(int n);
        int words;
        word_t w;
        job_words.delete();
        words = (n + 31) / 32;
        for (int i = 0; i < words; i++) begin
            w = $urandom();
            for (int b = 0; b < 32; b += 2) begin
                if (i * 32 + b < n) begin
                    w[b + 1] = ~w[b];
                end
            end
            job_words.push_back(w);
        end
    endfunction

    task automatic load_seed(word_t s);
        resp_t resp;
        bus_write(reg_seed, s, resp);
        check_resp("bresp of seed write", resp_okay, resp);
        model_state = (s == '0) ? word_t'(1) : s;
    endtask

    task automatic run_job(int n, string label);
        data_t status;
        resp_t resp;
        logic expected;
        bus_write(reg_count, data_t'(n), resp);
        check_resp({label, " count bresp"}, resp_okay, resp);
        bus_write(reg_ctrl, 32'h1, resp);
        check_resp({label, " ctrl bresp"}, resp_okay, resp);
        model_tie = model_state[0];
        model_state = lfsr_step(model_state);
        foreach (job_words[i]) begin
            bus_write(reg_data, job_words[i], resp);
            check_resp({label, " data bresp"}, resp_okay, resp);
        end
        wait_done(status);
        expected = expected_majority(n, model_tie);
        expected_status = data_t'({1'b0, expected, 1'b1});
        check_status({label, " status"}, expected_status, status);
    endtask

    initial begin
        data_t status;
        resp_t resp;
        int n;
        errors = 0;
        ready_delay_max = 0;
        model_state = 32'h1;
        expected_status = '0;
        rst = 1'b1;
        axil_req = '0;
        void'($urandom(32'h4926b55a));
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        // idle after reset
        bus_read(reg_status, status, resp);
        check_status("status after reset", 32'h0, status);
        check_resp("rresp after reset", resp_okay, resp);

        for (int j = 0; j < 40; j++) begin
            n = $urandom_range(300, 1);
            make_random_job(n, 1'b0);
            run_job(n, "random job");
        end

        // ties over several seeds, the fourth one zero
        for (int s = 0; s < 5; s++) begin
            load_seed((s == 3) ? 32'h0 : $urandom());
            for (int k = 0; k < 4; k++) begin
                n = 2 * $urandom_range(150, 1);
                make_tie_job(n);
                run_job(n, "tie job");
            end
        end

        for (int j = 0; j < 20; j++) begin
            n = 32 * $urandom_range(8, 0) + $urandom_range(31, 1);
            make_random_job(n, 1'b1);
            run_job(n, "partial job");
        end

        // words past the end of the job
        for (int k = 0; k < 3; k++) begin
            bus_write(reg_data, $urandom(), resp);
            check_resp("bresp of extra data write", resp_okay, resp);
        end
        for (int k = 0; k < 2; k++) begin
            bus_read(reg_status, status, resp);
            check_status("status after extra writes", expected_status, status);
        end

        bus_write(8'h14, $urandom(), resp);
        check_resp("bresp of unmapped write", resp_slverr, resp);
        bus_read(8'h20, status, resp);
        check_resp("rresp of unmapped read", resp_slverr, resp);

        // same jobs with a slow master on b and r
        ready_delay_max = 3;
        for (int j = 0; j < 20; j++) begin
            n = $urandom_range(300, 1);
            make_random_job(n, 1'b0);
            run_job(n, "delayed ready job");
        end

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* sources.f */
source/mv_pkg.sv
source/axil_pkg.sv
source/axil_regs.sv
source/word_sequencer.sv
source/tie_lfsr.sv
source/majority_counter.sv
source/majority_bundler.sv
bench/majority_bundler_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module majority_bundler_tb \
    -f sources.f -o sim_majority_bundler

output=$(./obj_dir/sim_majority_bundler)
echo "$output"

if echo "$output" | grep -qx "sim passed"; then
    exit 0
fi
exit 1
